// File: files.f
source/dmb_trig_pkg.sv
source/reset_sequencer.sv
source/cal_pulse_cond.sv
source/trig_encoder.sv
source/cable_delay_out.sv
source/trg_timer.sv
source/dmb_trigger_ctrl.sv
sim/tb_dmb_trigger_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the trigger controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
	--top-module tb_dmb_trigger_ctrl -o tb_dmb_trigger_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_dmb_trigger_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

// File: sim/tb_dmb_trigger_ctrl.sv
`default_nettype none

module tb_dmb_trigger_ctrl;

	localparam int N = dmb_trig_pkg::N_CFEB;
	localparam int LCT_TW = dmb_trig_pkg::LCT_TW;
	localparam int DAV_TW = dmb_trig_pkg::DAV_TW;
	localparam int POH = 64;
	localparam int LCT_MAX = (1 << LCT_TW) - 1;
	localparam int PATTERNS = 30;
	localparam int SAT_GAP = 1030;
	localparam int CFEB_OFS = 20;
	localparam int TMB_OFS = 12;
	localparam int ALCT_OFS = 5;
	// Saturation gap dominates and the rest adds about 300 cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic clkcms = 1'b0;
	logic clr0;
	logic [2:0] ccbcal_n_i;
	logic cal_trg_sel_i;
	logic jtag_trg_en_i;
	logic encode_i;
	logic cable_half_i;
	logic l1a_cfeb_i;
	logic [N-1:0] l1a_match_i;
	logic [N-1:0] pre_lct_i;
	logic lct_i;
	logic gpush_i;
	logic cfeb_dav_i;
	logic tmb_dav_i;
	logic alct_dav_i;
	logic dpush_i;
	logic readout_i;
	logic ctrl_ready_o;
	logic ped_o;
	logic inj_o;
	logic pls_o;
	logic [N-1:0] trg_enc_b0_o;
	logic [N-1:0] trg_enc_b1_o;
	logic [N-1:0] trg_enc_b2_o;
	dmb_trig_pkg::tm_count_u tm_count;

	string test_name = "reset_ready";
	int cycle = 0;
	int tick = 0;

	logic pat_valid;
	logic pat_d1;
	logic pat_d2;
	logic pat_d3;
	logic [3*N-1:0] exp_planes;
	logic [3*N-1:0] exp_d1;
	logic [3*N-1:0] exp_d2;
	logic [3*N-1:0] exp_d3;
	logic [3*N-1:0] act_planes;
	logic [2:0] cal_d1;
	logic [2:0] cal_d2;
	logic [2:0] cal_d3;
	logic gate_now;
	logic gate_d1;
	logic pls_exp;
	logic ready_exp;
	logic reset_window;
	logic [49:0] idle_outs;
	logic [LCT_TW-1:0] exp_lct;
	logic [DAV_TW-1:0] exp_cfeb;
	logic [DAV_TW-1:0] exp_tmb;
	logic [DAV_TW-1:0] exp_alct;
	logic [LCT_TW-1:0] lct_time;
	logic [DAV_TW-1:0] cfeb_time;
	logic [DAV_TW-1:0] tmb_time;
	logic [DAV_TW-1:0] alct_time;
	logic [3:0] pad_bits;

	dmb_trigger_ctrl #(
		.POH_CYCLES(POH)
	)
	dmb_trigger_ctrl_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.ccbcal_n_i(ccbcal_n_i),
		.cal_trg_sel_i(cal_trg_sel_i),
		.jtag_trg_en_i(jtag_trg_en_i),
		.encode_i(encode_i),
		.cable_half_i(cable_half_i),
		.l1a_cfeb_i(l1a_cfeb_i),
		.l1a_match_i(l1a_match_i),
		.pre_lct_i(pre_lct_i),
		.lct_i(lct_i),
		.gpush_i(gpush_i),
		.cfeb_dav_i(cfeb_dav_i),
		.tmb_dav_i(tmb_dav_i),
		.alct_dav_i(alct_dav_i),
		.dpush_i(dpush_i),
		.readout_i(readout_i),
		.ctrl_ready_o(ctrl_ready_o),
		.ped_o(ped_o),
		.inj_o(inj_o),
		.pls_o(pls_o),
		.trg_enc_b0_o(trg_enc_b0_o),
		.trg_enc_b1_o(trg_enc_b1_o),
		.trg_enc_b2_o(trg_enc_b2_o),
		.tm_count_o(tm_count)
	);

	always #2 clkcms = ~clkcms;

	//////////////////////////////////////////////////////////////////////
	// Error reporting
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic check_failed(input string check, input logic [63:0] expected,
		input logic [63:0] actual);
		stop_on_error($sformatf("FAILED %s (%s): expected %0h, actual %0h",
			test_name, check, expected, actual));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference values
	//////////////////////////////////////////////////////////////////////

	// Planes {b2, b1, b0} for one input set
	function automatic logic [3*N-1:0] expected_planes(input logic enc, input logic l1a,
		input logic [N-1:0] match, input logic [N-1:0] pre);
		logic [N-1:0] p0;
		logic [N-1:0] p1;
		logic [N-1:0] p2;
		logic [1:0] code;
		for (int i = 0; i < N; i++)
		begin
			if (!enc)
			begin
				p0[i] = match[i];
				p1[i] = pre[i];
				p2[i] = l1a;
			end
			else
			begin
				if (l1a && match[i])
					code = 2'd2;
				else if (pre[i])
					code = 2'd1;
				else
					code = 2'd0;
				p0[i] = code[0];
				p1[i] = code[1];
				p2[i] = 1'b0;
			end
		end
		return {p2, p1, p0};
	endfunction

	always_comb
	begin
		exp_planes = expected_planes(encode_i, l1a_cfeb_i, l1a_match_i, pre_lct_i);
		act_planes = {trg_enc_b2_o, trg_enc_b1_o, trg_enc_b0_o};
		// Toggle is low after the first edge, so it reads high on even cycles
		gate_now = ~cycle[0] | ~(cal_trg_sel_i & jtag_trg_en_i);
		pls_exp = (cal_d2[0] | cal_d3[0]) & gate_d1;
		ready_exp = (cycle > dmb_trig_pkg::READY_CYCLES);
		// Output register still holds the cleared encoder word one cycle after trigger reset
		reset_window = clr0 || (cycle <= dmb_trig_pkg::TRG_RST_CYCLES + 1);
		idle_outs = {act_planes, ped_o, inj_o, pls_o, tm_count.raw};
		lct_time = tm_count.f.lct_time;
		cfeb_time = tm_count.f.cfeb_time;
		tmb_time = tm_count.f.tmb_time;
		alct_time = tm_count.f.alct_time;
		pad_bits = {tm_count.f.pad_hi, tm_count.f.pad_mid};
	end

	// Latency lines for the trigger path and the calibration strobes
	always @(posedge clkcms)
	begin
		if (clr0)
		begin
			pat_d1 <= 1'b0;
			pat_d2 <= 1'b0;
			pat_d3 <= 1'b0;
			exp_d1 <= '0;
			exp_d2 <= '0;
			exp_d3 <= '0;
			cal_d1 <= '0;
			cal_d2 <= '0;
			cal_d3 <= '0;
			gate_d1 <= 1'b0;
			cycle <= 0;
		end
		else
		begin
			pat_d1 <= pat_valid;
			pat_d2 <= pat_d1;
			pat_d3 <= pat_d2;
			exp_d1 <= exp_planes;
			exp_d2 <= exp_d1;
			exp_d3 <= exp_d2;
			cal_d1 <= ~ccbcal_n_i;
			cal_d2 <= cal_d1;
			cal_d3 <= cal_d2;
			gate_d1 <= gate_now;
			cycle <= cycle + 1;
		end
	end

	always @(posedge clkcms)
	begin
		tick <= tick + 1;
		if (tick >= TIMEOUT_CYCLES)
			stop_on_error("Timeout: the run did not finish within the cycle limit");
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	reset_chk: assert property (@(posedge clkcms) (tick > 0 && reset_window) |-> idle_outs == '0)
		else check_failed("idle outputs", 64'(0), 64'($sampled(idle_outs)));

	ready_chk: assert property (@(posedge clkcms) disable iff (clr0) ctrl_ready_o == ready_exp)
		else check_failed("ctrl_ready_o", 64'($sampled(ready_exp)), 64'($sampled(ctrl_ready_o)));

	direct_chk: assert property (@(posedge clkcms) disable iff (clr0)
		(pat_d2 && !cable_half_i) |-> act_planes == exp_d2)
		else check_failed("planes", 64'($sampled(exp_d2)), 64'($sampled(act_planes)));

	cable_chk: assert property (@(posedge clkcms) disable iff (clr0)
		(pat_d3 && cable_half_i) |-> act_planes == exp_d3)
		else check_failed("planes", 64'($sampled(exp_d3)), 64'($sampled(act_planes)));

	ped_chk: assert property (@(posedge clkcms) disable iff (clr0) ped_o == cal_d2[2])
		else check_failed("ped_o", 64'($sampled(cal_d2[2])), 64'($sampled(ped_o)));

	inj_chk: assert property (@(posedge clkcms) disable iff (clr0) inj_o == cal_d2[1])
		else check_failed("inj_o", 64'($sampled(cal_d2[1])), 64'($sampled(inj_o)));

	pls_chk: assert property (@(posedge clkcms) disable iff (clr0) pls_o == pls_exp)
		else check_failed("pls_o", 64'($sampled(pls_exp)), 64'($sampled(pls_o)));

	lct_chk: assert property (@(posedge clkcms) disable iff (clr0) lct_time == exp_lct)
		else check_failed("lct_time", 64'($sampled(exp_lct)), 64'($sampled(lct_time)));

	cfeb_chk: assert property (@(posedge clkcms) disable iff (clr0) cfeb_time == exp_cfeb)
		else check_failed("cfeb_time", 64'($sampled(exp_cfeb)), 64'($sampled(cfeb_time)));

	tmb_chk: assert property (@(posedge clkcms) disable iff (clr0) tmb_time == exp_tmb)
		else check_failed("tmb_time", 64'($sampled(exp_tmb)), 64'($sampled(tmb_time)));

	alct_chk: assert property (@(posedge clkcms) disable iff (clr0) alct_time == exp_alct)
		else check_failed("alct_time", 64'($sampled(exp_alct)), 64'($sampled(alct_time)));

	pad_chk: assert property (@(posedge clkcms) disable iff (clr0) pad_bits == '0)
		else check_failed("pad bits", 64'(0), 64'($sampled(pad_bits)));

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clkcms);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	// Random planes in both encode modes, one cable setting
	task automatic run_patterns(input logic half);
		cable_half_i = half;
		idle(4);
		for (int m = 0; m < 2; m++)
		begin
			for (int p = 0; p < PATTERNS; p++)
			begin
				pat_valid = 1'b1;
				encode_i = m[0];
				l1a_cfeb_i = 1'($urandom);
				l1a_match_i = N'($urandom);
				pre_lct_i = N'($urandom);
				next_cycle();
			end
		end
		pat_valid = 1'b0;
		idle(4);
	endtask

	// LCT start, gpush stop gap cycles later
	task automatic measure_lct(input int gap, input logic blocked);
		lct_i = 1'b1;
		next_cycle();
		lct_i = 1'b0;
		// An accepted start drops the last latched time
		if (!blocked)
			exp_lct = '0;
		idle(gap - 1);
		gpush_i = 1'b1;
		next_cycle();
		gpush_i = 1'b0;
		if (!blocked)
			exp_lct = (gap >= LCT_MAX) ? LCT_TW'(LCT_MAX) : LCT_TW'(gap);
		idle(2);
	endtask

	// One cycle low on the given calibration lines, odd spacing
	task automatic cal_strobe(input logic [2:0] line_n);
		ccbcal_n_i = line_n;
		next_cycle();
		ccbcal_n_i = 3'b111;
		idle(4);
	endtask

	initial
	begin
		void'($urandom(80));
		clr0 = 1'b1;
		// Calibration lines active while clr0 is high
		ccbcal_n_i = 3'b000;
		cal_trg_sel_i = 1'b0;
		jtag_trg_en_i = 1'b0;
		encode_i = 1'b0;
		cable_half_i = 1'b0;
		// Trigger inputs busy through clr0 and the trigger reset
		l1a_cfeb_i = 1'b1;
		l1a_match_i = '1;
		pre_lct_i = '1;
		lct_i = 1'b0;
		gpush_i = 1'b0;
		cfeb_dav_i = 1'b0;
		tmb_dav_i = 1'b0;
		alct_dav_i = 1'b0;
		dpush_i = 1'b0;
		readout_i = 1'b0;
		pat_valid = 1'b0;
		exp_lct = '0;
		exp_cfeb = '0;
		exp_tmb = '0;
		exp_alct = '0;
		repeat (2) @(posedge clkcms);
		#1 clr0 = 1'b0;
		ccbcal_n_i = 3'b111;

		// Through the trigger reset and the ready count
		idle(24);

		// Still inside the power-on holdoff
		test_name = "lct_holdoff";
		measure_lct(5, 1'b1);

		test_name = "no_cable_delay";
		run_patterns(1'b0);
		test_name = "cable_delay";
		run_patterns(1'b1);
		cable_half_i = 1'b0;

		test_name = "cal_strobes";
		cal_strobe(3'b011);
		cal_strobe(3'b101);
		cal_strobe(3'b110);
		cal_strobe(3'b001);
		cal_trg_sel_i = 1'b1;
		cal_strobe(3'b110);
		cal_trg_sel_i = 1'b0;
		jtag_trg_en_i = 1'b1;
		cal_strobe(3'b110);
		cal_trg_sel_i = 1'b1;
		repeat (4) cal_strobe(3'b110);
		cal_trg_sel_i = 1'b0;
		jtag_trg_en_i = 1'b0;

		test_name = "lct_timer";
		measure_lct(37, 1'b0);
		test_name = "lct_saturate";
		measure_lct(SAT_GAP, 1'b0);

		test_name = "lct_readout";
		readout_i = 1'b1;
		next_cycle();
		readout_i = 1'b0;
		exp_lct = '0;
		idle(2);

		test_name = "dav_timers";
		cfeb_dav_i = 1'b1;
		next_cycle();
		cfeb_dav_i = 1'b0;
		idle(CFEB_OFS - TMB_OFS - 1);
		tmb_dav_i = 1'b1;
		next_cycle();
		tmb_dav_i = 1'b0;
		idle(TMB_OFS - ALCT_OFS - 1);
		alct_dav_i = 1'b1;
		next_cycle();
		alct_dav_i = 1'b0;
		idle(ALCT_OFS - 1);
		dpush_i = 1'b1;
		next_cycle();
		dpush_i = 1'b0;
		exp_cfeb = DAV_TW'(CFEB_OFS);
		exp_tmb = DAV_TW'(TMB_OFS);
		exp_alct = DAV_TW'(ALCT_OFS);
		idle(4);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/dmb_trigger_ctrl.sv
`default_nettype none

module dmb_trigger_ctrl #(
	parameter int POH_CYCLES = dmb_trig_pkg::POH_CYCLES_DEF
)
(
	input  wire                             clkcms,
	input  wire                             clr0,
	input  wire [2:0]                       ccbcal_n_i,
	input  wire                             cal_trg_sel_i,
	input  wire                             jtag_trg_en_i,
	input  wire                             encode_i,
	input  wire                             cable_half_i,
	input  wire                             l1a_cfeb_i,
	input  wire [dmb_trig_pkg::N_CFEB-1:0]  l1a_match_i,
	input  wire [dmb_trig_pkg::N_CFEB-1:0]  pre_lct_i,
	input  wire                             lct_i,
	input  wire                             gpush_i,
	input  wire                             cfeb_dav_i,
	input  wire                             tmb_dav_i,
	input  wire                             alct_dav_i,
	input  wire                             dpush_i,
	input  wire                             readout_i,
	output logic                            ctrl_ready_o,
	output logic                            ped_o,
	output logic                            inj_o,
	output logic                            pls_o,
	output logic [dmb_trig_pkg::N_CFEB-1:0] trg_enc_b0_o,
	output logic [dmb_trig_pkg::N_CFEB-1:0] trg_enc_b1_o,
	output logic [dmb_trig_pkg::N_CFEB-1:0] trg_enc_b2_o,
	output dmb_trig_pkg::tm_count_u         tm_count_o
);

	localparam int N = dmb_trig_pkg::N_CFEB;

	logic         trg_rst;
	logic         holdoff;
	logic         pls_inj_en;
	logic [N-1:0] enc_b0;
	logic [N-1:0] enc_b1;
	logic [N-1:0] enc_b2;

	logic [dmb_trig_pkg::LCT_TW-1:0] lct_time;
	logic [dmb_trig_pkg::DAV_TW-1:0] cfeb_time;
	logic [dmb_trig_pkg::DAV_TW-1:0] tmb_time;
	logic [dmb_trig_pkg::DAV_TW-1:0] alct_time;

	reset_sequencer #(
		.POH_CYCLES(POH_CYCLES)
	)
	reset_sequencer_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.trg_rst_o(trg_rst),
		.ctrl_ready_o(ctrl_ready_o),
		.holdoff_o(holdoff),
		.pls_inj_en_o(pls_inj_en)
	);

	cal_pulse_cond cal_pulse_cond_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.ccbcal_n_i(ccbcal_n_i),
		.pls_inj_en_i(pls_inj_en),
		.cal_trg_sel_i(cal_trg_sel_i),
		.jtag_trg_en_i(jtag_trg_en_i),
		.ped_o(ped_o),
		.inj_o(inj_o),
		.pls_o(pls_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Trigger path: encoder, cable delay, output register
	//////////////////////////////////////////////////////////////////////

	trig_encoder trig_encoder_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.trg_rst_i(trg_rst),
		.encode_i(encode_i),
		.l1a_cfeb_i(l1a_cfeb_i),
		.l1a_match_i(l1a_match_i),
		.pre_lct_i(pre_lct_i),
		.enc_b0_o(enc_b0),
		.enc_b1_o(enc_b1),
		.enc_b2_o(enc_b2)
	);

	cable_delay_out cable_delay_out_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.trg_rst_i(trg_rst),
		.cable_half_i(cable_half_i),
		.enc_b0_i(enc_b0),
		.enc_b1_i(enc_b1),
		.enc_b2_i(enc_b2),
		.trg_enc_b0_o(trg_enc_b0_o),
		.trg_enc_b1_o(trg_enc_b1_o),
		.trg_enc_b2_o(trg_enc_b2_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Latency timers
	//////////////////////////////////////////////////////////////////////

	// LCT to L1A push
	trg_timer #(
		.WIDTH(dmb_trig_pkg::LCT_TW)
	)
	lct_timer_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.holdoff_i(holdoff),
		.clear_i(readout_i),
		.start_i(lct_i),
		.stop_i(gpush_i),
		.time_o(lct_time)
	);

	// DAV to data push, one per source
	trg_timer #(
		.WIDTH(dmb_trig_pkg::DAV_TW)
	)
	cfeb_dav_timer_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.holdoff_i(holdoff),
		.clear_i(readout_i),
		.start_i(cfeb_dav_i),
		.stop_i(dpush_i),
		.time_o(cfeb_time)
	);

	trg_timer #(
		.WIDTH(dmb_trig_pkg::DAV_TW)
	)
	tmb_dav_timer_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.holdoff_i(holdoff),
		.clear_i(readout_i),
		.start_i(tmb_dav_i),
		.stop_i(dpush_i),
		.time_o(tmb_time)
	);

	trg_timer #(
		.WIDTH(dmb_trig_pkg::DAV_TW)
	)
	alct_dav_timer_i (
		.clkcms(clkcms),
		.clr0(clr0),
		.holdoff_i(holdoff),
		.clear_i(readout_i),
		.start_i(alct_dav_i),
		.stop_i(dpush_i),
		.time_o(alct_time)
	);

	// Readout word, pad bits stay zero
	always_comb
	begin
		tm_count_o.raw         = '0;
		tm_count_o.f.lct_time  = lct_time;
		tm_count_o.f.cfeb_time = cfeb_time;
		tm_count_o.f.tmb_time  = tmb_time;
		tm_count_o.f.alct_time = alct_time;
	end

endmodule

`default_nettype wire

// File: source/trg_timer.sv
`default_nettype none

module trg_timer #(
	parameter int WIDTH = 6
)
(
	input  wire              clkcms,
	input  wire              clr0,
	input  wire              holdoff_i,
	input  wire              clear_i,
	input  wire              start_i,
	input  wire              stop_i,
	output logic [WIDTH-1:0] time_o
);

	logic             running;
	logic [WIDTH-1:0] cnt;

	// Running count of cycles since start
	always_ff @(posedge clkcms)
	begin
		if (!running)
			cnt <= WIDTH'(1);
		else if (cnt != '1)
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			running <= 1'b0;
			time_o  <= '0;
		end
		else if (clear_i)
		begin
			running <= 1'b0;
			time_o  <= '0;
		end
		else if (running)
		begin
			// Hold the count at the stop strobe
			if (stop_i)
			begin
				running <= 1'b0;
				time_o  <= cnt;
			end
		end
		else if (start_i && !holdoff_i)
		begin
			running <= 1'b1;
			time_o  <= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/cable_delay_out.sv
`default_nettype none

module cable_delay_out (
	input  wire                            clkcms,
	input  wire                            clr0,
	input  wire                            trg_rst_i,
	input  wire                            cable_half_i,
	input  wire [dmb_trig_pkg::N_CFEB-1:0] enc_b0_i,
	input  wire [dmb_trig_pkg::N_CFEB-1:0] enc_b1_i,
	input  wire [dmb_trig_pkg::N_CFEB-1:0] enc_b2_i,
	output logic [dmb_trig_pkg::N_CFEB-1:0] trg_enc_b0_o,
	output logic [dmb_trig_pkg::N_CFEB-1:0] trg_enc_b1_o,
	output logic [dmb_trig_pkg::N_CFEB-1:0] trg_enc_b2_o
);

	localparam int N = dmb_trig_pkg::N_CFEB;

	logic [N-1:0] b0_dly;
	logic [N-1:0] b1_dly;
	logic [N-1:0] b2_dly;

	// Extra cycle for the longer cable
	always_ff @(posedge clkcms)
	begin
		b0_dly <= enc_b0_i;
		b1_dly <= enc_b1_i;
		b2_dly <= enc_b2_i;
	end

	// Output register
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			trg_enc_b0_o <= '0;
			trg_enc_b1_o <= '0;
			trg_enc_b2_o <= '0;
		end
		else if (trg_rst_i)
		begin
			trg_enc_b0_o <= '0;
			trg_enc_b1_o <= '0;
			trg_enc_b2_o <= '0;
		end
		else
		begin
			trg_enc_b0_o <= cable_half_i ? b0_dly : enc_b0_i;
			trg_enc_b1_o <= cable_half_i ? b1_dly : enc_b1_i;
			trg_enc_b2_o <= cable_half_i ? b2_dly : enc_b2_i;
		end
	end

endmodule

`default_nettype wire

// File: source/trig_encoder.sv
`default_nettype none

module trig_encoder (
	input  wire                            clkcms,
	input  wire                            clr0,
	input  wire                            trg_rst_i,
	input  wire                            encode_i,
	input  wire                            l1a_cfeb_i,
	input  wire [dmb_trig_pkg::N_CFEB-1:0] l1a_match_i,
	input  wire [dmb_trig_pkg::N_CFEB-1:0] pre_lct_i,
	output logic [dmb_trig_pkg::N_CFEB-1:0] enc_b0_o,
	output logic [dmb_trig_pkg::N_CFEB-1:0] enc_b1_o,
	output logic [dmb_trig_pkg::N_CFEB-1:0] enc_b2_o
);

	localparam int N = dmb_trig_pkg::N_CFEB;

	logic [N-1:0] hit;
	logic [N-1:0] b0_d;
	logic [N-1:0] b1_d;
	logic [N-1:0] b2_d;

	// L1A matched on this CFEB, code 2
	assign hit = {N{l1a_cfeb_i}} & l1a_match_i;

	//////////////////////////////////////////////////////////////////////
	// Plane selection
	//////////////////////////////////////////////////////////////////////

	// Encoded: 2 on a match, else 1 on pre-LCT, else 0
	// Direct: match, pre-LCT and L1A on planes 0, 1 and 2
	assign b0_d = encode_i ? (~hit & pre_lct_i) : l1a_match_i;
	assign b1_d = encode_i ? hit : pre_lct_i;
	assign b2_d = encode_i ? '0 : {N{l1a_cfeb_i}};

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			enc_b0_o <= '0;
			enc_b1_o <= '0;
			enc_b2_o <= '0;
		end
		else if (trg_rst_i)
		begin
			enc_b0_o <= '0;
			enc_b1_o <= '0;
			enc_b2_o <= '0;
		end
		else
		begin
			enc_b0_o <= b0_d;
			enc_b1_o <= b1_d;
			enc_b2_o <= b2_d;
		end
	end

endmodule

`default_nettype wire

// File: source/cal_pulse_cond.sv
`default_nettype none

module cal_pulse_cond (
	input  wire       clkcms,
	input  wire       clr0,
	input  wire [2:0] ccbcal_n_i,
	input  wire       pls_inj_en_i,
	input  wire       cal_trg_sel_i,
	input  wire       jtag_trg_en_i,
	output logic      ped_o,
	output logic      inj_o,
	output logic      pls_o
);

	// CCB calibration lines: 2 pedestal, 1 inject, 0 pulse
	logic ped_1;
	logic inj_1;
	logic pls_1;
	logic pls_2;
	logic pls_gate;

	// Pulse passes in every slot unless slot gating is requested
	assign pls_gate = pls_inj_en_i | ~(cal_trg_sel_i & jtag_trg_en_i);

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			ped_1 <= 1'b0;
			ped_o <= 1'b0;
			inj_1 <= 1'b0;
			inj_o <= 1'b0;
			pls_1 <= 1'b0;
			pls_2 <= 1'b0;
			pls_o <= 1'b0;
		end
		else
		begin
			// Active-low inputs, two register stages
			ped_1 <= ~ccbcal_n_i[2];
			ped_o <= ped_1;
			inj_1 <= ~ccbcal_n_i[1];
			inj_o <= inj_1;

			// Stretch over both stages, then gate
			pls_1 <= ~ccbcal_n_i[0];
			pls_2 <= pls_1;
			pls_o <= (pls_1 | pls_2) & pls_gate;
		end
	end

endmodule

`default_nettype wire

// File: source/reset_sequencer.sv
`default_nettype none

module reset_sequencer #(
	parameter int POH_CYCLES = dmb_trig_pkg::POH_CYCLES_DEF
)
(
	input  wire  clkcms,
	input  wire  clr0,
	output logic trg_rst_o,
	output logic ctrl_ready_o,
	output logic holdoff_o,
	output logic pls_inj_en_o
);

	localparam int RST_W = $clog2(dmb_trig_pkg::TRG_RST_CYCLES);
	localparam int RDY_W = $clog2(dmb_trig_pkg::READY_CYCLES + 1);
	localparam int POH_W = $clog2(POH_CYCLES);

	logic [RST_W-1:0] rst_cnt;
	logic [RDY_W-1:0] rdy_cnt;
	logic [POH_W-1:0] poh_cnt;
	logic             rst_last;

	// Last cycle of the trigger reset, also starts the holdoff
	assign rst_last = trg_rst_o && (rst_cnt == RST_W'(dmb_trig_pkg::TRG_RST_CYCLES - 1));

	//////////////////////////////////////////////////////////////////////
	// Trigger reset pulse
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			trg_rst_o <= 1'b1;
			rst_cnt   <= '0;
		end
		else if (trg_rst_o)
		begin
			rst_cnt <= rst_cnt + 1'b1;
			if (rst_last)
				trg_rst_o <= 1'b0;
		end
	end

	// Ready flag, sticky until the next clr0
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			ctrl_ready_o <= 1'b0;
			rdy_cnt      <= '0;
		end
		else if (!ctrl_ready_o)
		begin
			rdy_cnt <= rdy_cnt + 1'b1;
			if (rdy_cnt == RDY_W'(dmb_trig_pkg::READY_CYCLES))
				ctrl_ready_o <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Power-on holdoff for the timers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			holdoff_o <= 1'b0;
			poh_cnt   <= '0;
		end
		else if (rst_last)
		begin
			holdoff_o <= 1'b1;
			poh_cnt   <= '0;
		end
		else if (holdoff_o)
		begin
			poh_cnt <= poh_cnt + 1'b1;
			if (poh_cnt == POH_W'(POH_CYCLES - 1))
				holdoff_o <= 1'b0;
		end
	end

	// Pulse/inject slot toggle, low on the first edge after reset
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
			pls_inj_en_o <= 1'b1;
		else
			pls_inj_en_o <= ~pls_inj_en_o;
	end

endmodule

`default_nettype wire

// File: source/dmb_trig_pkg.sv
`default_nettype none

package dmb_trig_pkg;

	//////////////////////////////////////////////////////////////////////
	// Front-end geometry and sequencing lengths
	//////////////////////////////////////////////////////////////////////

	// Cathode front-end boards served by this controller
	localparam int N_CFEB = 5;

	// Trigger reset pulse after reset release
	localparam int TRG_RST_CYCLES = 16;

	// Count from reset release to controller ready
	localparam int READY_CYCLES = 16;

	// Power-on holdoff for the latency timers, shortened for simulation
	localparam int POH_CYCLES_DEF = 64;

	//////////////////////////////////////////////////////////////////////
	// Latency timer readout
	//////////////////////////////////////////////////////////////////////

	localparam int LCT_TW = 10;
	localparam int DAV_TW = 6;

	// One 32-bit readout word, also seen field by field
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [1:0]        pad_hi;
			logic [DAV_TW-1:0] alct_time;
			logic [1:0]        pad_mid;
			logic [DAV_TW-1:0] tmb_time;
			logic [DAV_TW-1:0] cfeb_time;
			logic [LCT_TW-1:0] lct_time;
		} f;
	} tm_count_u;

endpackage

`default_nettype wire
